/* src.f */
+incdir+.
axi2axil_pkg.sv
flow_fifo.sv
burst_sequencer.sv
axi2axil_core.sv
axi2axil_bridge.sv
tb_axil_mem.sv
tb_axi2axil.sv

/* tb_axi2axil.sv */
// Testbench for the AXI4 to AXI4-Lite bridge
// Issues INCR, WRAP, FIXED and reserved bursts against a lite memory and
// checks lite addresses, read beats and merged write responses

`include "axi2axil_defs.svh"

module tb_axi2axil;

  timeunit 1ns;
  timeprecision 100ps;

  import axi2axil_pkg::*;

  localparam int clk_period     = 20;
  localparam int num_bursts     = 31;
  localparam int timeout_cycles = 200 * num_bursts + 1000;

  logic        clk = 1'b0;
  logic        rst_n;
  axi_req_t    ar;
  logic        ar_valid;
  logic        ar_ready;
  axi_resp_t   r;
  logic        r_valid;
  logic        r_ready;
  axi_req_t    aw;
  logic        aw_valid;
  logic        aw_ready;
  axi_wdata_t  w;
  logic        w_valid;
  logic        w_ready;
  axi_resp_t   b;
  logic        b_valid;
  logic        b_ready;
  axil_req_t   lar;
  logic        lar_valid;
  logic        lar_ready;
  axil_resp_t  lr;
  logic        lr_valid;
  logic        lr_ready;
  axil_req_t   law;
  logic        law_valid;
  logic        law_ready;
  axil_wdata_t lw;
  logic        lw_valid;
  logic        lw_ready;
  axil_resp_t  lb;
  logic        lb_valid;
  logic        lb_ready;

  // Shadow of the responder memory and expected traffic
  logic [`AXI_DATA_WIDTH-1:0] shadow [1024];
  axil_req_t                  exp_lar [$];
  axil_req_t                  exp_law [$];
  axi_resp_t                  exp_r [$];
  axi_resp_t                  exp_b [$];
  int read_errs      = 0;
  int write_errs     = 0;
  int addr_errs      = 0;
  int other_errs     = 0;
  int rd_outstanding = 0;

  axi2axil_bridge u_axi2axil_bridge (.*);

  tb_axil_mem u_mem (.*);

  always #(clk_period / 2) clk = ~clk;

  // ----------------------------------------
  // Reference rules
  // ----------------------------------------
  // Address of beat idx by the AXI burst addressing rules
  function automatic logic [11:0] ref_beat_addr(input logic [11:0] start, input int len,
                                                input int size, input burst_t burst,
                                                input int idx);
    int s;
    int window;
    int offset;
    s = start;
    case (burst)
      INCR: return 12'(s + (idx << size));
      WRAP: begin
        window = (len + 1) << size;
        offset = ((s % window) + (idx << size)) % window;
        return 12'(s - (s % window) + offset);
      end
      default: return start;
    endcase
  endfunction

  function automatic logic in_err(input logic [11:0] addr);
    return (addr[11:10] == 2'b11);
  endfunction

  // Initial memory word unique to each word address
  function automatic logic [31:0] fill_word(input logic [9:0] idx);
    return {idx, 6'h15, ~idx, 6'h2a};
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_read(input axi_resp_t got, input axi_resp_t exp);
    if (got !== exp) begin
      read_errs++;
      $display("** Error @ %0t: R got id %0h resp %0d data %h last %b, exp %0h %0d %h %b",
               $time, got.id, got.resp, got.data, got.last, exp.id, exp.resp, exp.data, exp.last);
    end
  endtask

  task automatic check_write(input axi_resp_t got, input axi_resp_t exp);
    if (got !== exp) begin
      write_errs++;
      $display("** Error @ %0t: B got id %0h resp %0d, exp id %0h resp %0d",
               $time, got.id, got.resp, exp.id, exp.resp);
    end
  endtask

  task automatic check_addr(input axil_req_t got, input axil_req_t exp);
    if (got !== exp) begin
      addr_errs++;
      $display("** Error @ %0t: lite request got addr %h prot %0d, exp addr %h prot %0d",
               $time, got.addr, got.prot, exp.addr, exp.prot);
    end
  endtask

  // ----------------------------------------
  // Checker on every handshake
  // ----------------------------------------
  always @(posedge clk) begin
    if (rst_n) begin
      if (lar_valid && lar_ready) begin
        rd_outstanding++;
        if (exp_lar.size() == 0) begin
          other_errs++;
          $display("Lite read request at %0t was not expected", $time);
        end else begin
          check_addr(lar, exp_lar.pop_front());
        end
      end
      if (law_valid && law_ready) begin
        if (exp_law.size() == 0) begin
          other_errs++;
          $display("Lite write request at %0t was not expected", $time);
        end else begin
          check_addr(law, exp_law.pop_front());
        end
      end
      if (r_valid && r_ready) begin
        rd_outstanding--;
        if (exp_r.size() == 0) begin
          other_errs++;
          $display("Read beat at %0t was not expected", $time);
        end else begin
          check_read(r, exp_r.pop_front());
        end
      end
      if (b_valid && b_ready) begin
        if (exp_b.size() == 0) begin
          other_errs++;
          $display("Write response at %0t was not expected", $time);
        end else begin
          check_write(b, exp_b.pop_front());
        end
      end
      if (rd_outstanding > `AXI_MAX_OUTSTANDING) begin
        other_errs++;
        $display("Too many reads in flight at %0t: %0d", $time, rd_outstanding);
      end
    end
  end

  // Random stalls on the AXI4 response channels
  always @(negedge clk) begin
    r_ready = ($urandom_range(3) != 0);
    b_ready = ($urandom_range(2) != 0);
  end

  // ----------------------------------------
  // Burst stimulus
  // ----------------------------------------
  task automatic issue_read(input logic [11:0] addr, input logic [3:0] id, input int len,
                            input int size, input burst_t burst);
    logic [11:0] a;
    axi_resp_t   e;
    int          i;
    // Reads only after every write has landed
    while (exp_b.size() != 0) @(posedge clk);
    for (i = 0; i <= len; i++) begin
      a = ref_beat_addr(addr, len, size, burst, i);
      exp_lar.push_back('{addr: a, prot: 3'(id)});
      e.id   = id;
      e.last = (i == len);
      e.resp = in_err(a) ? SLVERR : OKAY;
      e.data = in_err(a) ? '0 : shadow[a[11:2]];
      exp_r.push_back(e);
    end
    @(negedge clk);
    ar       = '{addr: addr, id: id, len: 8'(len), size: 3'(size), burst: burst, prot: 3'(id)};
    ar_valid = 1'b1;
    @(posedge clk);
    while (!ar_ready) @(posedge clk);
    @(negedge clk);
    ar_valid = 1'b0;
  endtask

  task automatic issue_write(input logic [11:0] addr, input logic [3:0] id, input int len,
                             input int size, input burst_t burst);
    logic [11:0] a;
    logic [31:0] wdata [8];
    logic [3:0]  wstrb [8];
    resp_t       resp;
    int          i;
    int          k;
    // Writes wait for pending reads so read data stays predictable
    while (exp_r.size() != 0) @(posedge clk);
    resp = OKAY;
    for (i = 0; i <= len; i++) begin
      a        = ref_beat_addr(addr, len, size, burst, i);
      wdata[i] = $urandom;
      wstrb[i] = 4'($urandom_range(15, 1));
      exp_law.push_back('{addr: a, prot: 3'(id)});
      // First error of the burst decides the merged response
      if (in_err(a)) begin
        if (resp == OKAY) resp = SLVERR;
      end else begin
        for (k = 0; k < 4; k++) begin
          if (wstrb[i][k]) shadow[a[11:2]][k*8 +: 8] = wdata[i][k*8 +: 8];
        end
      end
    end
    exp_b.push_back('{id: id, resp: resp, data: '0, last: 1'b1});
    @(negedge clk);
    aw       = '{addr: addr, id: id, len: 8'(len), size: 3'(size), burst: burst, prot: 3'(id)};
    aw_valid = 1'b1;
    @(posedge clk);
    while (!aw_ready) @(posedge clk);
    @(negedge clk);
    aw_valid = 1'b0;
    for (i = 0; i <= len; i++) begin
      w       = '{data: wdata[i], strb: wstrb[i], last: (i == len)};
      w_valid = 1'b1;
      @(posedge clk);
      while (!w_ready) @(posedge clk);
      @(negedge clk);
    end
    w_valid = 1'b0;
  endtask

  // Watchdog
  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("Run timed out after %0d cycles with transfers still pending", timeout_cycles);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    int          i;
    int          len;
    logic [11:0] addr;
    burst_t      burst;
    // Fixed seed for the whole run
    void'($urandom(32'h741a_b6a2));
    rst_n    = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    r_ready  = 1'b0;
    b_ready  = 1'b0;
    for (i = 0; i < 1024; i++) begin
      u_mem.mem[i] = fill_word(10'(i));
      shadow[i]    = fill_word(10'(i));
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // INCR write then read back with 1 to 8 beats
    issue_write(12'h100, 4'h1, 0, 2, INCR);
    issue_read(12'h100, 4'h2, 0, 2, INCR);
    issue_write(12'h110, 4'h3, 3, 2, INCR);
    issue_read(12'h110, 4'h4, 3, 2, INCR);
    issue_write(12'h140, 4'h5, 7, 2, INCR);
    issue_read(12'h140, 4'h6, 7, 2, INCR);
    issue_read(12'h142, 4'h7, 5, 1, INCR);
    // WRAP from the middle of a 16-byte window
    issue_read(12'h208, 4'h8, 3, 2, WRAP);
    // FIXED and reserved stay on the start address
    issue_read(12'h040, 4'h9, 3, 2, FIXED);
    issue_read(12'h044, 4'ha, 2, 2, RSVD);
    issue_write(12'h050, 4'hb, 2, 2, FIXED);
    // Merged B response for error bursts followed by a clean one
    issue_write(12'hbf8, 4'hc, 3, 2, INCR);
    // Error beats first and OKAY beats once the address wraps past the top
    issue_write(12'hff8, 4'hf, 3, 2, INCR);
    issue_write(12'h300, 4'hd, 1, 2, INCR);
    // Per-beat read errors across the boundary
    issue_read(12'hbf8, 4'he, 3, 2, INCR);

    // Mixed bursts with random IDs under stalls
    for (i = 0; i < 16; i++) begin
      case ($urandom_range(2))
        0: burst = FIXED;
        1: burst = INCR;
        default: burst = WRAP;
      endcase
      if (burst == WRAP) begin
        len = (2 << $urandom_range(2)) - 1;
      end else begin
        len = $urandom_range(7);
      end
      addr = 12'($urandom_range(4095)) & 12'hffc;
      if ($urandom_range(1) != 0) begin
        issue_read(addr, 4'($urandom_range(15)), len, 2, burst);
      end else begin
        issue_write(addr, 4'($urandom_range(15)), len, 2, burst);
      end
    end

    while (exp_r.size() != 0 || exp_b.size() != 0) @(posedge clk);
    repeat (5) @(posedge clk);
    if (exp_lar.size() != 0 || exp_law.size() != 0) begin
      other_errs++;
      $display("Lite requests expected but never seen");
    end
    $display("Errors: read %0d, write %0d, address %0d, other %0d",
             read_errs, write_errs, addr_errs, other_errs);
    if (read_errs + write_errs + addr_errs + other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* tb_axil_mem.sv */
// AXI4-Lite memory responder for the bridge testbench
// 1K words, random ready stalls, SLVERR where address bits 11:10 are 2'b11

`include "axi2axil_defs.svh"

module tb_axil_mem (
  input  logic                      clk,
  input  logic                      rst_n,
  input  axi2axil_pkg::axil_req_t   lar,
  input  logic                      lar_valid,
  output logic                      lar_ready,
  output axi2axil_pkg::axil_resp_t  lr,
  output logic                      lr_valid,
  input  logic                      lr_ready,
  input  axi2axil_pkg::axil_req_t   law,
  input  logic                      law_valid,
  output logic                      law_ready,
  input  axi2axil_pkg::axil_wdata_t lw,
  input  logic                      lw_valid,
  output logic                      lw_ready,
  output axi2axil_pkg::axil_resp_t  lb,
  output logic                      lb_valid,
  input  logic                      lb_ready
);

  timeunit 1ns;
  timeprecision 100ps;

  import axi2axil_pkg::*;

  // Word storage, filled by the testbench at time zero
  logic [`AXI_DATA_WIDTH-1:0] mem [1024];
  axil_resp_t                 rd_q [$];
  axil_resp_t                 wr_q [$];
  logic                       wr_go;
  int                         b;

  function automatic logic in_err(input logic [`AXI_ADDR_WIDTH-1:0] addr);
    return (addr[11:10] == 2'b11);
  endfunction

  // Address and data of a write are taken together
  assign law_ready = wr_go && law_valid && lw_valid;
  assign lw_ready  = law_ready;

  initial begin
    lar_ready = 1'b0;
    wr_go     = 1'b0;
    lr_valid  = 1'b0;
    lb_valid  = 1'b0;
    lr        = '0;
    lb        = '0;
  end

  // ----------------------------------------
  // Accept requests, queue and return responses
  // ----------------------------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      lar_ready <= 1'b0;
      wr_go     <= 1'b0;
      lr_valid  <= 1'b0;
      lb_valid  <= 1'b0;
      rd_q.delete();
      wr_q.delete();
    end else begin
      // Ready about three cycles in four
      lar_ready <= ($urandom_range(3) != 0);
      wr_go     <= ($urandom_range(3) != 0);
      if (lar_valid && lar_ready) begin
        if (in_err(lar.addr)) begin
          rd_q.push_back('{resp: SLVERR, data: '0});
        end else begin
          rd_q.push_back('{resp: OKAY, data: mem[lar.addr[11:2]]});
        end
      end
      if (law_valid && law_ready) begin
        if (in_err(law.addr)) begin
          wr_q.push_back('{resp: SLVERR, data: '0});
        end else begin
          // Byte lanes under strobe only
          for (b = 0; b < `AXI_STRB_WIDTH; b++) begin
            if (lw.strb[b]) begin
              mem[law.addr[11:2]][b*8 +: 8] <= lw.data[b*8 +: 8];
            end
          end
          wr_q.push_back('{resp: OKAY, data: '0});
        end
      end
      // Output slots reload only once free, with a random gap
      if (!lr_valid || lr_ready) begin
        if (rd_q.size() != 0 && $urandom_range(3) != 0) begin
          lr       <= rd_q.pop_front();
          lr_valid <= 1'b1;
        end else begin
          lr_valid <= 1'b0;
        end
      end
      if (!lb_valid || lb_ready) begin
        if (wr_q.size() != 0 && $urandom_range(3) != 0) begin
          lb       <= wr_q.pop_front();
          lb_valid <= 1'b1;
        end else begin
          lb_valid <= 1'b0;
        end
      end
    end
  end

endmodule

/* axi2axil_bridge.sv */
// AXI4 to AXI4-Lite bridge top
// Separate burst cores for the read and the write direction

module axi2axil_bridge (
  input  logic                      clk,
  input  logic                      rst_n,
  // AXI4 read address and data
  input  axi2axil_pkg::axi_req_t    ar,
  input  logic                      ar_valid,
  output logic                      ar_ready,
  output axi2axil_pkg::axi_resp_t   r,
  output logic                      r_valid,
  input  logic                      r_ready,
  // AXI4 write address, data and response
  input  axi2axil_pkg::axi_req_t    aw,
  input  logic                      aw_valid,
  output logic                      aw_ready,
  input  axi2axil_pkg::axi_wdata_t  w,
  input  logic                      w_valid,
  output logic                      w_ready,
  output axi2axil_pkg::axi_resp_t   b,
  output logic                      b_valid,
  input  logic                      b_ready,
  // AXI4-Lite read
  output axi2axil_pkg::axil_req_t   lar,
  output logic                      lar_valid,
  input  logic                      lar_ready,
  input  axi2axil_pkg::axil_resp_t  lr,
  input  logic                      lr_valid,
  output logic                      lr_ready,
  // AXI4-Lite write
  output axi2axil_pkg::axil_req_t   law,
  output logic                      law_valid,
  input  logic                      law_ready,
  output axi2axil_pkg::axil_wdata_t lw,
  output logic                      lw_valid,
  input  logic                      lw_ready,
  input  axi2axil_pkg::axil_resp_t  lb,
  input  logic                      lb_valid,
  output logic                      lb_ready
);

  // ----------------------------------------
  // Read direction, AR to LAR and LR to R
  // ----------------------------------------
  axi2axil_core #(
    .is_read (1'b1)
  ) u_read_core (
    .clk              (clk),
    .rst_n            (rst_n),
    .axi_req          (ar),
    .axi_req_valid    (ar_valid),
    .axi_req_ready    (ar_ready),
    .axi_wdata        (),
    .axi_wdata_valid  (),
    .axi_wdata_ready  (),
    .axi_resp         (r),
    .axi_resp_valid   (r_valid),
    .axi_resp_ready   (r_ready),
    .axil_req         (lar),
    .axil_req_valid   (lar_valid),
    .axil_req_ready   (lar_ready),
    .axil_wdata       (),
    .axil_wdata_valid (),
    .axil_wdata_ready (),
    .axil_resp        (lr),
    .axil_resp_valid  (lr_valid),
    .axil_resp_ready  (lr_ready)
  );

  // ----------------------------------------
  // Write direction, AW and W to LAW and LW, LB to B
  // ----------------------------------------
  axi2axil_core #(
    .is_read (1'b0)
  ) u_write_core (
    .clk              (clk),
    .rst_n            (rst_n),
    .axi_req          (aw),
    .axi_req_valid    (aw_valid),
    .axi_req_ready    (aw_ready),
    .axi_wdata        (w),
    .axi_wdata_valid  (w_valid),
    .axi_wdata_ready  (w_ready),
    .axi_resp         (b),
    .axi_resp_valid   (b_valid),
    .axi_resp_ready   (b_ready),
    .axil_req         (law),
    .axil_req_valid   (law_valid),
    .axil_req_ready   (law_ready),
    .axil_wdata       (lw),
    .axil_wdata_valid (lw_valid),
    .axil_wdata_ready (lw_ready),
    .axil_resp        (lb),
    .axil_resp_valid  (lb_valid),
    .axil_resp_ready  (lb_ready)
  );

endmodule

/* axi2axil_core.sv */
// AXI4 to AXI4-Lite burst core
// Turns one AXI4 request channel into single-beat lite requests and
// folds the lite responses back into AXI4 responses
// is_read picks per-beat read data or one merged write response

`include "axi2axil_defs.svh"

module axi2axil_core #(
  parameter bit is_read = 1'b1
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // AXI4 request, AR or AW
  input  axi2axil_pkg::axi_req_t      axi_req,
  input  logic                        axi_req_valid,
  output logic                        axi_req_ready,
  // AXI4 write data
  input  axi2axil_pkg::axi_wdata_t    axi_wdata,
  input  logic                        axi_wdata_valid,
  output logic                        axi_wdata_ready,
  // AXI4 response, R or B
  output axi2axil_pkg::axi_resp_t     axi_resp,
  output logic                        axi_resp_valid,
  input  logic                        axi_resp_ready,
  // Lite request
  output axi2axil_pkg::axil_req_t     axil_req,
  output logic                        axil_req_valid,
  input  logic                        axil_req_ready,
  // Lite write data
  output axi2axil_pkg::axil_wdata_t   axil_wdata,
  output logic                        axil_wdata_valid,
  input  logic                        axil_wdata_ready,
  // Lite response
  input  axi2axil_pkg::axil_resp_t    axil_resp,
  input  logic                        axil_resp_valid,
  output logic                        axil_resp_ready
);

  import axi2axil_pkg::*;

  // Two slots of the budget sit in the request register
  localparam int req_depth = 2;
  localparam int trk_depth = `AXI_MAX_OUTSTANDING - req_depth;

  axi_req_t                   cur_req;
  logic                       req_held;
  logic                       req_pop;
  logic [`AXI_ADDR_WIDTH-1:0] beat_addr;
  logic                       last_beat;
  logic                       lite_req_xfer;
  logic                       lite_resp_xfer;
  tracker_t                   trk_push;
  tracker_t                   trk_head;
  logic                       trk_ready;
  logic                       trk_valid;

  // ----------------------------------------
  // Request register and sequencer
  // ----------------------------------------
  flow_fifo #(
    .payload_t (axi_req_t),
    .depth     (req_depth)
  ) u_req_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (axi_req_valid),
    .push_ready (axi_req_ready),
    .push_data  (axi_req),
    .pop_valid  (req_held),
    .pop_ready  (req_pop),
    .pop_data   (cur_req)
  );

  // Lite beat goes out only while the tracker has room for it
  assign axil_req_valid = req_held && trk_ready;
  assign lite_req_xfer  = axil_req_valid && axil_req_ready;
  // Request leaves with its final beat
  assign req_pop        = lite_req_xfer && last_beat;

  burst_sequencer u_burst_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (cur_req),
    .start     (req_pop),
    .beat_done (lite_req_xfer),
    .beat_addr (beat_addr),
    .last_beat (last_beat)
  );

  assign axil_req.addr = beat_addr;
  assign axil_req.prot = cur_req.prot;

  // ----------------------------------------
  // Response tracker
  // ----------------------------------------
  assign trk_push.id   = cur_req.id;
  assign trk_push.last = last_beat;

  flow_fifo #(
    .payload_t (tracker_t),
    .depth     (trk_depth)
  ) u_trk_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (lite_req_xfer),
    .push_ready (trk_ready),
    .push_data  (trk_push),
    .pop_valid  (trk_valid),
    .pop_ready  (lite_resp_xfer),
    .pop_data   (trk_head)
  );

  // Responses arrive only for tracked beats, head valid is implied
  assign lite_resp_xfer = axil_resp_valid && axil_resp_ready && trk_valid;
  assign axi_resp.id    = trk_head.id;

  // ----------------------------------------
  // Read or write specific paths
  // ----------------------------------------
  if (is_read) begin : gen_read
    // No write data on this side
    assign axil_wdata       = '0;
    assign axil_wdata_valid = 1'b0;
    assign axi_wdata_ready  = 1'b0;

    // Every lite response is one R beat
    assign axi_resp.resp   = axil_resp.resp;
    assign axi_resp.data   = axil_resp.data;
    assign axi_resp.last   = trk_head.last;
    assign axi_resp_valid  = axil_resp_valid;
    assign axil_resp_ready = axi_resp_ready;
  end else begin : gen_write
    resp_t merged_resp;
    logic  b_xfer;

    // W passes straight through, wlast is not needed
    assign axil_wdata.data  = axi_wdata.data;
    assign axil_wdata.strb  = axi_wdata.strb;
    assign axil_wdata_valid = axi_wdata_valid;
    assign axi_wdata_ready  = axil_wdata_ready;

    // Only the last beat produces B, earlier beats drain freely
    assign axi_resp_valid  = axil_resp_valid && trk_head.last;
    assign axil_resp_ready = !trk_head.last || axi_resp_ready;
    assign b_xfer          = axi_resp_valid && axi_resp_ready;

    // First error of the burst wins, otherwise the current beat
    assign axi_resp.resp = (merged_resp != OKAY) ? merged_resp : axil_resp.resp;
    assign axi_resp.data = '0;
    assign axi_resp.last = 1'b1;

    // Merge register, back to OKAY after each B
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        merged_resp <= OKAY;
      end else if (b_xfer) begin
        merged_resp <= OKAY;
      end else if (lite_resp_xfer && merged_resp == OKAY) begin
        merged_resp <= axil_resp.resp;
      end
    end
  end

endmodule

/* burst_sequencer.sv */
// Burst beat sequencer
// Counts beats of the held AXI4 request and forms each beat address
// for INCR, WRAP and FIXED bursts

`include "axi2axil_defs.svh"

module burst_sequencer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  axi2axil_pkg::axi_req_t     req,
  input  logic                       start,
  input  logic                       beat_done,
  output logic [`AXI_ADDR_WIDTH-1:0] beat_addr,
  output logic                       last_beat
);

  import axi2axil_pkg::*;

  logic [`AXI_LEN_WIDTH-1:0]  beat_idx;
  logic [`AXI_ADDR_WIDTH-1:0] incr_addr;
  logic [`AXI_ADDR_WIDTH-1:0] wrap_mask;

  // ----------------------------------------
  // Beat counter
  // ----------------------------------------
  // Cleared when the request leaves the request register, which also
  // covers the last beat transfer of the burst
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_idx <= '0;
    end else if (start) begin
      beat_idx <= '0;
    end else if (beat_done) begin
      beat_idx <= beat_idx + 1'b1;
    end
  end

  assign last_beat = (beat_idx == req.len);

  // ----------------------------------------
  // Address generation
  // ----------------------------------------
  // Byte offset of this beat
  assign incr_addr = req.addr + (`AXI_ADDR_WIDTH'(beat_idx) << req.size);

  // Window size is (len + 1) beats of 2^size bytes
  assign wrap_mask = ((`AXI_ADDR_WIDTH'(req.len) + 1'b1) << req.size) - 1'b1;

  always_comb begin
    case (req.burst)
      INCR: beat_addr = incr_addr;
      // Keep upper bits of the aligned window, wrap the low part
      WRAP: beat_addr = (req.addr & ~wrap_mask) | (incr_addr & wrap_mask);
      // FIXED and reserved type stay on the start address
      default: beat_addr = req.addr;
    endcase
  end

endmodule

/* flow_fifo.sv */
// Valid/ready FIFO built from flops
// Payload type is a parameter, no bypass, so an empty FIFO shows
// new data one cycle after the push

module flow_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push_valid,
  output logic     push_ready,
  input  payload_t push_data,
  output logic     pop_valid,
  input  logic     pop_ready,
  output payload_t pop_data
);

  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_width = $clog2(depth + 1);

  payload_t             mem [depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [cnt_width-1:0] count;
  logic                 do_push;
  logic                 do_pop;

  // Pointer step with wrap for any depth, not only powers of two
  function automatic logic [ptr_width-1:0] ptr_step(input logic [ptr_width-1:0] ptr);
    if (ptr == ptr_width'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ----------------------------------------
  // Handshakes and status
  // ----------------------------------------
  assign push_ready = (count != cnt_width'(depth));
  assign pop_valid  = (count != '0);
  assign do_push    = push_valid && push_ready;
  assign do_pop     = pop_valid && pop_ready;

  // Head entry straight from the array
  assign pop_data = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_step(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_step(rd_ptr);
      end
      // Count moves only when exactly one side transfers
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* axi2axil_pkg.sv */
// AXI4 to AXI4-Lite bridge types
// Burst and response encodings plus one packed struct per channel

`include "axi2axil_defs.svh"

package axi2axil_pkg;

  // AXI burst encoding, RSVD handled like FIXED
  typedef enum logic [1:0] {
    FIXED  = 2'b00,
    INCR   = 2'b01,
    WRAP   = 2'b10,
    RSVD   = 2'b11
  } burst_t;

  // AXI response encoding
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_t;

  // ----------------------------------------
  // AXI4 side
  // ----------------------------------------

  // AR and AW request
  typedef struct packed {
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [`AXI_ID_WIDTH-1:0]   id;
    logic [`AXI_LEN_WIDTH-1:0]  len;
    logic [`AXI_SIZE_WIDTH-1:0] size;
    burst_t                     burst;
    logic [`AXI_PROT_WIDTH-1:0] prot;
  } axi_req_t;

  // W beat
  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic [`AXI_STRB_WIDTH-1:0] strb;
    logic                       last;
  } axi_wdata_t;

  // R beat, B reuses it with data zero and last set
  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0]   id;
    resp_t                      resp;
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic                       last;
  } axi_resp_t;

  // ----------------------------------------
  // AXI4-Lite side
  // ----------------------------------------

  typedef struct packed {
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [`AXI_PROT_WIDTH-1:0] prot;
  } axil_req_t;

  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic [`AXI_STRB_WIDTH-1:0] strb;
  } axil_wdata_t;

  // R and B share this, data unused for B
  typedef struct packed {
    resp_t                      resp;
    logic [`AXI_DATA_WIDTH-1:0] data;
  } axil_resp_t;

  // One entry per outstanding lite beat
  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0] id;
    logic                     last;
  } tracker_t;

endpackage

/* axi2axil_defs.svh */
// AXI4 to AXI4-Lite bridge widths and depths
// Shared by the package and the RTL

`ifndef AXI2AXIL_DEFS_SVH
`define AXI2AXIL_DEFS_SVH

// Address and data bus widths
`define AXI_ADDR_WIDTH 12
`define AXI_DATA_WIDTH 32
`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)

// AXI4 request fields
`define AXI_ID_WIDTH   4
`define AXI_LEN_WIDTH  8
`define AXI_SIZE_WIDTH 3
`define AXI_PROT_WIDTH 3

// Beats in flight per core, request register included
`define AXI_MAX_OUTSTANDING 8

`endif
